// File: dma_bus_pkg.sv
// ----------------------------------------------------------
// dma bus package
// memory side types: byte addresses, byte counts, the row
// descriptor and the per-pixel read request
// ----------------------------------------------------------
package dma_bus_pkg;

    localparam int ADDR_W = 32;                   // byte address width
    localparam int LEN_W  = 16;                   // byte count width
    localparam int PCNT_W = 8;                    // same width as a spatial dimension

    typedef logic [ADDR_W-1:0] addr_t;            // byte address
    typedef logic [LEN_W-1:0]  len_t;             // request length or stride in bytes
    typedef logic [PCNT_W-1:0] pix_cnt_t;         // pixels in one tile row

    // ----------------------------------------------------------
    // one tile row, as seen by the burst engine
    // ----------------------------------------------------------
    typedef struct packed {
        addr_t    base_addr;                      // first channel of first pixel
        len_t     pix_bytes;                      // bytes read per pixel
        len_t     pix_stride;                     // step from pixel to pixel
        pix_cnt_t pix_count;                      // pixels in the row
        logic     last;                           // final row of the layer
    } row_desc_t;

    // one read request on the memory port
    typedef struct packed {
        addr_t addr;                              // byte address
        len_t  len;                               // bytes to read
        logic  last;                              // final request of the layer
    } mem_req_t;

endpackage

// File: dma_layer_pkg.sv
// ----------------------------------------------------------
// dma layer package
// layer geometry types, layer kind, the layer configuration
// and the row command passed from sequencer to generator
// ----------------------------------------------------------
package dma_layer_pkg;

    localparam int DIM_W  = 8;                    // rows / columns up to 255
    localparam int CHAN_W = 11;                   // channels up to 1024

    typedef logic [DIM_W-1:0]  dim_t;             // row or column count / coordinate
    typedef logic [CHAN_W-1:0] chan_t;            // channel count / coordinate

    // convolution kind of the layer
    typedef enum logic {
        kind_pw = 1'b0,                           // pointwise, tile_d channels per pixel
        kind_dw = 1'b1                            // depthwise, one channel per pixel
    } layer_kind_e;

    // ----------------------------------------------------------
    // everything needed to fetch one input feature map
    // ----------------------------------------------------------
    typedef struct packed {
        layer_kind_e        kind;                 // pw or dw
        dim_t               in_r;                 // map rows
        dim_t               in_c;                 // map columns
        dim_t               tile_r;               // tile rows
        dim_t               tile_c;               // tile columns
        chan_t              in_d;                 // map channels
        chan_t              tile_d;               // tile channels, pw only
        dma_bus_pkg::addr_t base_ifmap;           // byte address of element (0,0,0)
    } layer_cfg_t;

    // one tile row, in map coordinates
    typedef struct packed {
        dim_t  row;                               // map row of the tile row
        dim_t  col;                               // first map column
        chan_t chan;                              // first channel
        chan_t chan_w;                            // channels per pixel
        logic  last;                              // final row of the layer
    } row_cmd_t;

endpackage

// File: dma_tile_sequencer.sv
// ----------------------------------------------------------
// dma tile sequencer
// walks the layer tile by tile and emits one row command per
// tile row, row within tile fastest, then channel, column and
// row tile
// ----------------------------------------------------------
`timescale 1ns/1ps

module dma_tile_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go,          // start walking, cfg is stable
    input  dma_layer_pkg::layer_cfg_t cfg,
    input  logic                      cmd_ready,
    output dma_layer_pkg::row_cmd_t   cmd,
    output logic                      cmd_valid,
    output logic                      idle
);

    logic                 running;                 // walk in progress
    dma_layer_pkg::dim_t  row_tile;                // row-tile origin
    dma_layer_pkg::dim_t  col_tile;                // column-tile origin
    dma_layer_pkg::chan_t chan_tile;               // channel-tile origin
    dma_layer_pkg::dim_t  tile_row;                // row inside the tile
    dma_layer_pkg::chan_t chan_step;               // channel width of a tile

    logic row_end;                                 // last row of the tile
    logic chan_end;                                // last channel tile
    logic col_end;                                 // last column tile
    logic rt_end;                                  // last row tile
    logic take;                                    // command handshake

    // ----------------------------------------------------------
    // channel tiling, dw walks every channel as its own tile
    // ----------------------------------------------------------
    assign chan_step = (cfg.kind == dma_layer_pkg::kind_pw) ? cfg.tile_d
                                                            : dma_layer_pkg::chan_t'(1);

    // final values, dims are whole multiples of the tile sizes
    assign row_end  = (tile_row == cfg.tile_r - 8'd1);
    assign chan_end = (chan_tile == cfg.in_d - chan_step);
    assign col_end  = (col_tile == cfg.in_c - cfg.tile_c);
    assign rt_end   = (row_tile == cfg.in_r - cfg.tile_r);

    assign take = cmd_valid && cmd_ready;

    // command straight from the counters, holds while stalled
    always_comb begin
        cmd.row    = row_tile + tile_row;         // map row
        cmd.col    = col_tile;                    // first column of the tile
        cmd.chan   = chan_tile;
        cmd.chan_w = chan_step;
        cmd.last   = row_end && chan_end && col_end && rt_end;
    end

    assign cmd_valid = running;
    assign idle      = !running;

    // ----------------------------------------------------------
    // nested counters
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running   <= 1'b0;
            row_tile  <= '0;
            col_tile  <= '0;
            chan_tile <= '0;
            tile_row  <= '0;
        end else if (go && !running) begin
            running   <= 1'b1;                     // first command next cycle
            row_tile  <= '0;
            col_tile  <= '0;
            chan_tile <= '0;
            tile_row  <= '0;
        end else if (take) begin
            if (cmd.last) begin
                running <= 1'b0;                   // layer fully issued
            end
            if (row_end) begin
                tile_row <= '0;
                if (chan_end) begin
                    chan_tile <= '0;
                    if (col_end) begin
                        col_tile <= '0;
                        row_tile <= row_tile + cfg.tile_r;   // next row tile
                    end else begin
                        col_tile <= col_tile + cfg.tile_c;
                    end
                end else begin
                    chan_tile <= chan_tile + chan_step;      // next channel tile
                end
            end else begin
                tile_row <= tile_row + 8'd1;
            end
        end
    end

endmodule

// File: dma_addr_generator.sv
// ----------------------------------------------------------
// dma address generator
// one register stage, turns a row command into a row
// descriptor with base address, pixel bytes and pixel stride
// ----------------------------------------------------------
`timescale 1ns/1ps

module dma_addr_generator #(
    parameter int DATA_BYTES = 2                   // bytes per element
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dma_layer_pkg::layer_cfg_t cfg,
    input  dma_layer_pkg::row_cmd_t   cmd,
    input  logic                      cmd_valid,
    input  logic                      desc_ready,
    output logic                      cmd_ready,
    output dma_bus_pkg::row_desc_t    desc,
    output logic                      desc_valid
);

    localparam dma_bus_pkg::addr_t ELEM_ADDR = dma_bus_pkg::addr_t'(DATA_BYTES);
    localparam dma_bus_pkg::len_t  ELEM_LEN  = dma_bus_pkg::len_t'(DATA_BYTES);

    dma_bus_pkg::addr_t     pix_index;             // row * in_c + col
    dma_bus_pkg::addr_t     elem_index;            // element offset of first channel
    dma_bus_pkg::row_desc_t desc_next;             // descriptor for the incoming cmd
    dma_bus_pkg::row_desc_t desc_q;                // pipeline slot
    logic                   valid_q;               // slot holds a descriptor
    logic                   load;                  // command handshake

    // ----------------------------------------------------------
    // address arithmetic, [r][c][d] element order
    // ----------------------------------------------------------
    always_comb begin
        pix_index  = dma_bus_pkg::addr_t'(cmd.row) * dma_bus_pkg::addr_t'(cfg.in_c)
                   + dma_bus_pkg::addr_t'(cmd.col);
        elem_index = pix_index * dma_bus_pkg::addr_t'(cfg.in_d)
                   + dma_bus_pkg::addr_t'(cmd.chan);

        desc_next.base_addr  = cfg.base_ifmap + elem_index * ELEM_ADDR;
        desc_next.pix_bytes  = dma_bus_pkg::len_t'(cmd.chan_w) * ELEM_LEN;  // per pixel read
        desc_next.pix_stride = dma_bus_pkg::len_t'(cfg.in_d) * ELEM_LEN;    // one full pixel
        desc_next.pix_count  = cfg.tile_c;                                  // pixels per row
        desc_next.last       = cmd.last;
    end

    // free slot, or slot drains this cycle
    assign cmd_ready = !valid_q || desc_ready;
    assign load      = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (desc_ready) begin
            valid_q <= 1'b0;                       // taken, nothing new
        end
    end

    // payload only, valid_q qualifies it
    always_ff @(posedge clk) begin
        if (load) begin
            desc_q <= desc_next;
        end
    end

    assign desc       = desc_q;
    assign desc_valid = valid_q;

endmodule

// File: dma_burst_engine.sv
// ----------------------------------------------------------
// dma burst engine
// expands each row descriptor into one read request per
// pixel, stepping the address by the pixel stride
// ----------------------------------------------------------
`timescale 1ns/1ps

module dma_burst_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dma_bus_pkg::row_desc_t desc,
    input  logic                   desc_valid,
    input  logic                   mem_req_ready,
    output logic                   desc_ready,
    output dma_bus_pkg::mem_req_t  mem_req,
    output logic                   mem_req_valid
);

    typedef enum logic {
        st_idle,                                   // no descriptor held
        st_issue                                   // presenting pixel requests
    } state_e;

    state_e                state;
    dma_bus_pkg::addr_t    cur_addr;               // address of current pixel
    dma_bus_pkg::pix_cnt_t remain;                 // pixels left incl. current
    dma_bus_pkg::len_t     pix_bytes;
    dma_bus_pkg::len_t     pix_stride;
    logic                  row_last;               // row is the final one of the layer

    logic fire;                                    // request handshake
    logic final_pix;                               // current pixel ends the row
    logic take;                                    // descriptor handshake

    // ----------------------------------------------------------
    // handshakes
    // ----------------------------------------------------------
    assign final_pix = (remain == 8'd1);
    assign fire      = mem_req_valid && mem_req_ready;

    // back to back rows, next descriptor on the last pixel
    assign desc_ready = (state == st_idle) || (fire && final_pix);
    assign take       = desc_valid && desc_ready;

    // request straight from the holding registers
    always_comb begin
        mem_req.addr = cur_addr;
        mem_req.len  = pix_bytes;
        mem_req.last = row_last && final_pix;      // end of the layer
    end

    assign mem_req_valid = (state == st_issue);

    // ----------------------------------------------------------
    // state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else if (take) begin
            state <= st_issue;                     // new row, or chained row
        end else if (fire && final_pix) begin
            state <= st_idle;                      // row done, nothing queued
        end
    end

    // pixel walk
    always_ff @(posedge clk) begin
        if (take) begin
            cur_addr   <= desc.base_addr;
            remain     <= desc.pix_count;
            pix_bytes  <= desc.pix_bytes;
            pix_stride <= desc.pix_stride;
            row_last   <= desc.last;
        end else if (fire) begin
            cur_addr <= cur_addr + dma_bus_pkg::addr_t'(pix_stride);   // next pixel
            remain   <= remain - 8'd1;
        end
    end

endmodule

// File: dma_tile_loader.sv
// ----------------------------------------------------------
// dma tile loader
// ifmap fetch front end: start / busy / done control around
// the tile sequencer, address generator and burst engine
// ----------------------------------------------------------
`timescale 1ns/1ps

module dma_tile_loader #(
    parameter int DATA_BYTES = 2                   // bytes per element
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,       // one cycle, ignored while busy
    input  dma_layer_pkg::layer_cfg_t cfg,
    output logic                      busy,
    output logic                      done,        // one cycle after last request
    output dma_bus_pkg::mem_req_t     mem_req,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready
);

    dma_layer_pkg::layer_cfg_t cfg_q;              // layer held for the whole run
    dma_layer_pkg::row_cmd_t   cmd;
    dma_bus_pkg::row_desc_t    desc;
    logic cmd_valid, cmd_ready;
    logic desc_valid, desc_ready;
    logic go;                                      // sequencer kick, cycle after latch
    logic seq_idle;
    logic accept;                                  // start taken
    logic final_xfer;                              // last request of the layer moves

    assign accept     = start && !busy && seq_idle;
    assign final_xfer = mem_req_valid && mem_req_ready && mem_req.last;

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            go   <= 1'b0;
        end else begin
            go   <= accept;
            done <= final_xfer;
            if (accept) begin
                busy <= 1'b1;
            end else if (final_xfer) begin
                busy <= 1'b0;                      // falls with done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_q <= cfg;                          // sampled on start
        end
    end

    dma_tile_sequencer u_seq (
        .clk, .rst_n, .go, .cfg(cfg_q), .cmd_ready, .cmd, .cmd_valid, .idle(seq_idle)
    );

    dma_addr_generator #(.DATA_BYTES(DATA_BYTES)) u_agen (
        .clk, .rst_n, .cfg(cfg_q), .cmd, .cmd_valid, .desc_ready,
        .cmd_ready, .desc, .desc_valid
    );

    dma_burst_engine u_burst (
        .clk, .rst_n, .desc, .desc_valid, .mem_req_ready, .desc_ready, .mem_req, .mem_req_valid
    );

endmodule

// File: dma_tile_loader_properties.sv
// ----------------------------------------------------------
// dma tile loader properties
// request handshake, busy / valid relation and done pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module dma_tile_loader_properties #(
    parameter int DATA_BYTES = 2                   // bytes per element
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  busy,
    input logic                  done,
    input dma_bus_pkg::mem_req_t mem_req,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready
);

    int fail_count = 0;                            // failed assertions so far

    // stalled request holds valid and payload
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else begin
            $error("request changed while stalled");
            fail_count++;
        end

    a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> busy)                    // no requests outside a run
        else begin
            $error("request valid while not busy");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)                            // single cycle only
        else begin
            $error("done held longer than one cycle");
            fail_count++;
        end

    a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> ((mem_req.addr % DATA_BYTES) == 0))
        else begin
            $error("request address not element aligned");
            fail_count++;
        end

endmodule

bind dma_tile_loader dma_tile_loader_properties #(.DATA_BYTES(DATA_BYTES)) u_props (
    .clk(clk), .rst_n(rst_n), .busy(busy), .done(done), .mem_req(mem_req),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready)
);

// File: tb_dma_tile_loader.sv
// ----------------------------------------------------------
// dma tile loader testbench
// pw and dw layers, lfsr back-pressure, reference request
// model and a transfer checker
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_dma_tile_loader;

    localparam int DATA_BYTES = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    dma_layer_pkg::layer_cfg_t cfg;
    logic                      busy;
    logic                      done;
    dma_bus_pkg::mem_req_t     mem_req;
    logic                      mem_req_valid;
    logic                      mem_req_ready;

    dma_layer_pkg::layer_cfg_t exp_cfg;            // layer the checker follows
    int                        exp_total;          // requests expected for it
    int                        req_idx;            // requests seen so far
    int                        done_count;         // done pulses seen
    logic                      bp_en;              // random back-pressure on
    logic [31:0]               lfsr_state;

    dma_tile_loader #(.DATA_BYTES(DATA_BYTES)) dut (
        .clk, .rst_n, .start, .cfg, .busy, .done, .mem_req, .mem_req_valid, .mem_req_ready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];          // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %0t ns: %s is %h, expected %h", $time, what, got, expected);
            abort_run("first mismatch ends the run");
        end
    endtask

    function automatic dma_layer_pkg::layer_cfg_t make_cfg(
        input dma_layer_pkg::layer_kind_e kind, input int in_r, input int in_c,
        input int in_d, input int tile_r, input int tile_c, input int tile_d,
        input logic [31:0] base);
        dma_layer_pkg::layer_cfg_t c;
        c.kind       = kind;
        c.in_r       = dma_layer_pkg::dim_t'(in_r);
        c.in_c       = dma_layer_pkg::dim_t'(in_c);
        c.in_d       = dma_layer_pkg::chan_t'(in_d);
        c.tile_r     = dma_layer_pkg::dim_t'(tile_r);
        c.tile_c     = dma_layer_pkg::dim_t'(tile_c);
        c.tile_d     = dma_layer_pkg::chan_t'(tile_d);
        c.base_ifmap = base;
        return c;
    endfunction

    // channels per request, dw reads one channel per pixel
    function automatic int chan_width(input dma_layer_pkg::layer_cfg_t c);
        return (c.kind == dma_layer_pkg::kind_pw) ? int'(c.tile_d) : 1;
    endfunction

    function automatic int request_count(input dma_layer_pkg::layer_cfg_t c);
        return int'(c.in_r) * int'(c.in_c) * (int'(c.in_d) / chan_width(c));
    endfunction

    // ----------------------------------------------------------
    // reference model, n-th request of a layer
    // pixel fastest, then tile row, channel tile, column tile, row tile
    // ----------------------------------------------------------
    function automatic dma_bus_pkg::mem_req_t expected_req(
        input dma_layer_pkg::layer_cfg_t c, input int n);
        dma_bus_pkg::mem_req_t r;
        int cw;
        int n_chan_t;
        int n_col_t;
        int k;
        int pix;
        int trow;
        int chan_t;
        int col_t;
        int row_t;
        int row;
        int col;
        int chan;
        cw       = chan_width(c);
        n_chan_t = int'(c.in_d) / cw;
        n_col_t  = int'(c.in_c) / int'(c.tile_c);
        pix      = n % int'(c.tile_c);
        k        = n / int'(c.tile_c);
        trow     = k % int'(c.tile_r);
        k        = k / int'(c.tile_r);
        chan_t   = k % n_chan_t;
        k        = k / n_chan_t;
        col_t    = k % n_col_t;
        row_t    = k / n_col_t;
        row      = row_t * int'(c.tile_r) + trow;
        col      = col_t * int'(c.tile_c) + pix;
        chan     = chan_t * cw;
        r.addr   = c.base_ifmap
                 + 32'(((row * int'(c.in_c) + col) * int'(c.in_d) + chan) * DATA_BYTES);
        r.len    = 16'(cw * DATA_BYTES);
        r.last   = (n == request_count(c) - 1);
        return r;
    endfunction

    // ----------------------------------------------------------
    // checker, compares every transfer with the model
    // ----------------------------------------------------------
    always @(posedge clk) begin : compare_requests
        dma_bus_pkg::mem_req_t exp_req;
        check_value("assertion failures", 32'(dut.u_props.fail_count), 32'd0);
        if (rst_n) begin
            if (done) begin
                done_count = done_count + 1;
            end
            if (mem_req_valid && mem_req_ready) begin
                check_value("request index in range", 32'(req_idx < exp_total), 32'd1);
                check_value("busy during request", 32'(busy), 32'd1);
                exp_req = expected_req(exp_cfg, req_idx);
                check_value("request addr", mem_req.addr, exp_req.addr);
                check_value("request len", 32'(mem_req.len), 32'(exp_req.len));
                check_value("request last", 32'(mem_req.last), 32'(exp_req.last));
                req_idx = req_idx + 1;
            end
        end
    end

    // back-pressure, one lfsr step per ready bit
    always @(posedge clk) begin : drive_ready
        logic bp_cur;                              // mode for this cycle
        bp_cur = bp_en;
        #1;
        if (bp_cur) begin
            lfsr_state    = lfsr_next(lfsr_state);
            mem_req_ready = lfsr_state[0];
        end else begin
            mem_req_ready = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // one layer, start to done; extra_at < 0 means no second start
    // ----------------------------------------------------------
    task automatic run_layer(input dma_layer_pkg::layer_cfg_t c, input logic bp,
                             input int extra_at);
        dma_layer_pkg::layer_cfg_t alt;
        int   cycles;
        int   limit;
        logic seen_done;
        alt            = c;
        alt.base_ifmap = c.base_ifmap + 32'h0010_0000;   // must never show up
        if (c.kind == dma_layer_pkg::kind_pw) begin
            alt.kind = dma_layer_pkg::kind_dw;
        end else begin
            alt.kind = dma_layer_pkg::kind_pw;
        end
        exp_cfg    = c;
        exp_total  = request_count(c);
        req_idx    = 0;
        done_count = 0;
        bp_en      = bp;
        cfg        = c;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("busy after start", 32'(busy), 32'd1);
        cycles    = 0;
        seen_done = 1'b0;
        limit     = 64 + exp_total * 16;
        while (!seen_done) begin
            if (cycles == extra_at) begin
                cfg   = alt;                       // start while busy
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            if (done) begin
                seen_done = 1'b1;
            end else begin
                check_value("busy before done", 32'(busy), 32'd1);
                if (cycles > limit) begin
                    abort_run("timeout: done did not arrive for the running layer");
                end
            end
        end
        start = 1'b0;
        check_value("busy with done", 32'(busy), 32'd0);
        check_value("request count", 32'(req_idx), 32'(exp_total));
        @(posedge clk);
        #1;
        check_value("done after one cycle", 32'(done), 32'd0);
        check_value("done pulses", 32'(done_count), 32'd1);
    endtask

    // nothing more may follow a finished layer
    task automatic check_quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            check_value("valid while idle", 32'(mem_req_valid), 32'd0);
            check_value("busy while idle", 32'(busy), 32'd0);
        end
        check_value("requests after done", 32'(req_idx), 32'(exp_total));
        check_value("done pulses after idle", 32'(done_count), 32'd1);
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        dma_layer_pkg::layer_cfg_t pw_a;
        dma_layer_pkg::layer_cfg_t dw_a;
        dma_layer_pkg::layer_cfg_t pw_b;
        dma_layer_pkg::layer_cfg_t dw_b;
        rst_n         = 1'b0;
        start         = 1'b0;
        cfg           = '0;
        mem_req_ready = 1'b1;
        bp_en         = 1'b0;
        lfsr_state    = 32'h8ab941a6;
        exp_cfg       = '0;
        exp_total     = 0;
        req_idx       = 0;
        done_count    = 0;
        pw_a = make_cfg(dma_layer_pkg::kind_pw, 4, 4, 8, 2, 2, 4, 32'h0000_1000);
        dw_a = make_cfg(dma_layer_pkg::kind_dw, 4, 4, 3, 2, 2, 5, 32'h2000_0040);  // tile_d unused
        pw_b = make_cfg(dma_layer_pkg::kind_pw, 6, 4, 16, 3, 2, 8, 32'h0004_0000);
        dw_b = make_cfg(dma_layer_pkg::kind_dw, 2, 6, 4, 1, 3, 1, 32'h0100_0002);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("busy after reset", 32'(busy), 32'd0);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("valid after reset", 32'(mem_req_valid), 32'd0);

        run_layer(pw_a, 1'b0, -1);                 // pw, ready always high
        run_layer(dw_a, 1'b0, -1);                 // dw, one channel per tile
        run_layer(pw_a, 1'b1, -1);                 // same layers under stall
        run_layer(dw_a, 1'b1, -1);
        run_layer(pw_b, 1'b1, 7);                  // second start ignored
        check_quiet(20);
        run_layer(dw_b, 1'b1, -1);                 // back to back, new base and kind
        run_layer(pw_b, 1'b0, -1);
        check_quiet(10);

        if (dut.u_props.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("bound assertions failed during the run");
        end
    end

endmodule

// File: compile.f
dma_bus_pkg.sv
dma_layer_pkg.sv
dma_tile_sequencer.sv
dma_addr_generator.sv
dma_burst_engine.sv
dma_tile_loader.sv
dma_tile_loader_properties.sv
tb_dma_tile_loader.sv

// File: Bender.yml
package:
  name: dma_tile_loader

sources:
  # packages, bus types first
  - dma_bus_pkg.sv
  - dma_layer_pkg.sv
  # rtl
  - dma_tile_sequencer.sv
  - dma_addr_generator.sv
  - dma_burst_engine.sv
  - dma_tile_loader.sv
  # testbench
  - target: test
    files:
      - dma_tile_loader_properties.sv
      - tb_dma_tile_loader.sv
